// File: src/ex_pkg.sv
// execute-stage types; VLEN fixed at 128 bits, SEW up to 32, no RV32M/RV32C/CSR support
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    // vector register length in bytes
    localparam int VLEN_BYTES = 16;
    // widest VLMAX: SEW8 with LMUL8
    localparam int VLMAX_MAX  = VLEN_BYTES * 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // port a sources
    typedef enum logic [1:0] {A_RS1, A_IMM_S, A_PC, A_ZERO} alu_a_sel_e;
    // port b sources
    typedef enum logic [1:0] {B_RS1, B_RS2, B_IMM_OR_SHAMT, B_IMM_U} alu_b_sel_e;

    // follows funct3 of the branch opcodes
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_type_e;

    typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} vsetvl_type_e;

    // codes 3 and up are reserved
    typedef enum logic [2:0] {SEW8 = 3'd0, SEW16 = 3'd1, SEW32 = 3'd2} vsew_e;

    // code 4 reserved
    typedef enum logic [2:0] {
        LMUL1      = 3'd0,
        LMUL2      = 3'd1,
        LMUL4      = 3'd2,
        LMUL8      = 3'd3,
        LMULEIGHTH = 3'd5,
        LMULFOURTH = 3'd6,
        LMULHALF   = 3'd7
    } vlmul_e;

    typedef struct packed {
        logic        vill;
        logic [22:0] zero;
        logic        vma;
        logic        vta;
        vsew_e       vsew;
        vlmul_e      vlmul;
    } vtype_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t rd;
        logic     branch_taken;
        logic     illegal;
        word_t    result;
        word_t    brj_addr;
        vtype_t   vtype;
        word_t    pc;
    } ex_mem_t;

endpackage

// File: src/ex_operand_if.sv
// combinational operand bundle, driven by a single source each cycle; no handshake
interface ex_operand_if;
    import ex_pkg::*;

    // register values after forwarding
    word_t rs1_val;
    word_t rs2_val;
    // sign-extended immediates
    word_t imm_i_ext;
    word_t imm_uj_ext;
    word_t imm_sb_ext;
    word_t pc;
    word_t pc4;

    modport src (
        output rs1_val, rs2_val, imm_i_ext, imm_uj_ext, imm_sb_ext, pc, pc4
    );

    modport sink (
        input rs1_val, rs2_val, imm_i_ext, imm_uj_ext, imm_sb_ext, pc, pc4
    );

endinterface

// File: src/reg_file.sv
// write visible only the cycle after wen; no internal write-to-read bypass
module reg_file (
    input  logic            CLK,
    input  logic            nRST,
    input  ex_pkg::reg_idx_t rs1_idx,
    input  ex_pkg::reg_idx_t rs2_idx,
    input  logic            wen,
    input  ex_pkg::reg_idx_t rd,
    input  ex_pkg::word_t   wdata,
    output ex_pkg::word_t   rs1_data,
    output ex_pkg::word_t   rs2_data
);
    import ex_pkg::*;

    word_t regs [NUM_REGS];

    // x0 never written
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // async reads, x0 hardwired
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // a write aimed at x0 must leave its storage at zero
    a_x0_zero: assert property (@(posedge CLK) disable iff (!nRST)
        (wen && rd == '0) |=> (regs[0] == '0))
        else $error("x0 storage nonzero after write to x0");

endmodule

// File: src/ex_operand_sel.sv
// fwd_data is the only forwarding source (memory stage); hazard detection is external
module ex_operand_sel (
    input  ex_pkg::word_t      rs1_data,
    input  ex_pkg::word_t      rs2_data,
    input  logic               fwd_rs1,
    input  logic               fwd_rs2,
    input  ex_pkg::word_t      fwd_data,
    input  ex_pkg::word_t      pc_in,
    input  ex_pkg::word_t      pc4_in,
    input  logic [11:0]        imm_i,
    input  logic [11:0]        imm_s,
    input  logic [12:0]        imm_sb,
    input  logic [20:0]        imm_uj,
    input  ex_pkg::word_t      imm_u,
    input  logic [4:0]         shamt,
    input  logic               imm_shamt_sel,
    input  ex_pkg::alu_a_sel_e alu_a_sel,
    input  ex_pkg::alu_b_sel_e alu_b_sel,
    input  ex_pkg::alu_op_e    alu_op_in,
    ex_operand_if.src          ops,
    output ex_pkg::word_t      alu_a,
    output ex_pkg::word_t      alu_b,
    output ex_pkg::alu_op_e    alu_op
);
    import ex_pkg::*;

    word_t imm_s_ext;
    word_t imm_or_shamt;

    // memory-stage forwarding overrides the register file
    assign ops.rs1_val = fwd_rs1 ? fwd_data : rs1_data;
    assign ops.rs2_val = fwd_rs2 ? fwd_data : rs2_data;

    assign ops.imm_i_ext  = {{20{imm_i[11]}}, imm_i};
    assign ops.imm_sb_ext = {{19{imm_sb[12]}}, imm_sb};
    assign ops.imm_uj_ext = {{11{imm_uj[20]}}, imm_uj};
    assign imm_s_ext      = {{20{imm_s[11]}}, imm_s};
    assign ops.pc         = pc_in;
    assign ops.pc4        = pc4_in;

    // immediate shifts take shamt, zero-extended
    assign imm_or_shamt = imm_shamt_sel ? {27'b0, shamt} : ops.imm_i_ext;

    always_comb begin
        case (alu_a_sel)
            A_RS1:   alu_a = ops.rs1_val;
            A_IMM_S: alu_a = imm_s_ext;
            A_PC:    alu_a = pc_in;
            default: alu_a = '0;
        endcase
    end

    always_comb begin
        case (alu_b_sel)
            B_RS1:          alu_b = ops.rs1_val;
            B_RS2:          alu_b = ops.rs2_val;
            B_IMM_OR_SHAMT: alu_b = imm_or_shamt;
            default:        alu_b = imm_u;
        endcase
    end

    assign alu_op = alu_op_in;

endmodule

// File: src/alu.sv
// RV32I only; shift amount taken from b[4:0], no overflow flag
module alu (
    input  ex_pkg::word_t   a,
    input  ex_pkg::word_t   b,
    input  ex_pkg::alu_op_e op,
    output ex_pkg::word_t   result
);
    import ex_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            default:  result = '0;
        endcase
    end

endmodule

// File: src/branch_jump_unit.sv
// no prediction; next PC is resolved fully in this stage, misaligned targets not trapped
module branch_jump_unit (
    ex_operand_if.sink           ops,
    input  ex_pkg::branch_type_e branch_type,
    input  logic                 is_branch,
    input  logic                 is_jump,
    input  logic                 j_sel,
    output logic                 branch_taken,
    output ex_pkg::word_t        brj_addr
);
    import ex_pkg::*;

    logic  cond;
    word_t jump_addr;
    word_t jalr_sum;
    word_t branch_addr;

    always_comb begin
        case (branch_type)
            BEQ:     cond = (ops.rs1_val == ops.rs2_val);
            BNE:     cond = (ops.rs1_val != ops.rs2_val);
            BLT:     cond = ($signed(ops.rs1_val) < $signed(ops.rs2_val));
            BGE:     cond = ($signed(ops.rs1_val) >= $signed(ops.rs2_val));
            BLTU:    cond = (ops.rs1_val < ops.rs2_val);
            BGEU:    cond = (ops.rs1_val >= ops.rs2_val);
            default: cond = 1'b0;
        endcase
    end

    // condition only counts for real branches
    assign branch_taken = is_branch && cond;

    // jalr clears bit 0 of the sum
    assign jalr_sum  = ops.rs1_val + ops.imm_i_ext;
    assign jump_addr = j_sel ? (ops.pc + ops.imm_uj_ext) : {jalr_sum[31:1], 1'b0};

    assign branch_addr = ops.pc + ops.imm_sb_ext;

    // jump wins, then taken branch, else fall through
    always_comb begin
        if (is_jump) begin
            brj_addr = jump_addr;
        end else if (branch_taken) begin
            brj_addr = branch_addr;
        end else begin
            brj_addr = ops.pc4;
        end
    end

endmodule

// File: src/vcfg_unit.sv
// VLEN 128, SEW up to 32; vl goes to the pipeline only, no vl/vtype CSR update here
module vcfg_unit (
    ex_operand_if.sink           ops,
    input  ex_pkg::vsetvl_type_e vsetvl_type,
    input  logic [10:0]          vtype_imm,
    input  logic [4:0]           zimm,
    input  ex_pkg::reg_idx_t     rs1_idx,
    output ex_pkg::word_t        vl,
    output ex_pkg::vtype_t       vtype_out
);
    import ex_pkg::*;

    vtype_t vtype_req;
    word_t  vlmax_sew;
    word_t  vlmax;
    word_t  avl;
    logic   sew_ok;
    logic   lmul_ok;
    logic   vill;

    // vsetvl takes vtype from rs2, the others from the immediate
    assign vtype_req = (vsetvl_type == VSETVL) ? vtype_t'(ops.rs2_val)
                                               : vtype_t'({21'b0, vtype_imm});

    // elements per register at this SEW
    always_comb begin
        sew_ok = 1'b1;
        case (vtype_req.vsew)
            SEW8:  vlmax_sew = word_t'(VLEN_BYTES);
            SEW16: vlmax_sew = word_t'(VLEN_BYTES >> 1);
            SEW32: vlmax_sew = word_t'(VLEN_BYTES >> 2);
            default: begin
                vlmax_sew = '0;
                sew_ok    = 1'b0;
            end
        endcase
    end

    // scale by register group, fractional LMUL shifts right
    always_comb begin
        lmul_ok = 1'b1;
        case (vtype_req.vlmul)
            LMUL1:      vlmax = vlmax_sew;
            LMUL2:      vlmax = vlmax_sew << 1;
            LMUL4:      vlmax = vlmax_sew << 2;
            LMUL8:      vlmax = vlmax_sew << 3;
            LMULHALF:   vlmax = vlmax_sew >> 1;
            LMULFOURTH: vlmax = vlmax_sew >> 2;
            LMULEIGHTH: vlmax = vlmax_sew >> 3;
            default: begin
                vlmax   = '0;
                lmul_ok = 1'b0;
            end
        endcase
    end

    // upper field covers vill too, a set vill request is itself illegal
    assign vill = !sew_ok || !lmul_ok || (vtype_req[31:8] != '0);

    always_comb begin
        avl = (vsetvl_type == VSETIVLI) ? {27'b0, zimm} : ops.rs1_val;
        // rs1 = x0 requests VLMAX
        if ((vsetvl_type == VSETVL || vsetvl_type == VSETVLI) && rs1_idx == '0) begin
            avl = vlmax;
        end else if (avl > vlmax) begin
            avl = vlmax;
        end
    end

    assign vl = vill ? '0 : avl;

    always_comb begin
        vtype_out = vtype_req;
        if (vill) begin
            vtype_out      = '0;
            vtype_out.vill = 1'b1;
        end
    end

    // SEW8 with LMUL8 bounds the whole clamp chain
    always_comb begin
        a_vl_bound: assert final (vl <= word_t'(VLMAX_MAX))
            else $error("vl %0d exceeds VLMAX bound", vl);
    end

endmodule

// File: src/ex_mem_reg.sv
// stall beats flush; flush and reset clear the whole record to zero
module ex_mem_reg (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 valid_in,
    input  logic                 reg_write_in,
    input  ex_pkg::reg_idx_t     rd_in,
    input  logic                 illegal_in,
    input  ex_pkg::vsetvl_type_e vsetvl_type,
    ex_operand_if.sink           ops,
    input  ex_pkg::word_t        alu_result,
    input  logic                 branch_taken,
    input  ex_pkg::word_t        brj_addr,
    input  ex_pkg::word_t        vl,
    input  ex_pkg::vtype_t       vtype,
    output ex_pkg::ex_mem_t      q
);
    import ex_pkg::*;

    ex_mem_t d;
    logic    is_cfg;

    assign is_cfg = (vsetvl_type != NOT_CFG);

    always_comb begin
        d.valid = valid_in;
        // illegal squashes side effects but still travels down
        d.reg_write    = reg_write_in && !illegal_in;
        d.branch_taken = branch_taken && !illegal_in;
        d.illegal      = illegal_in;
        d.rd           = rd_in;
        // vsetvl family writes vl to rd
        d.result   = is_cfg ? vl : alu_result;
        d.brj_addr = brj_addr;
        d.vtype    = is_cfg ? vtype : '0;
        d.pc       = ops.pc;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            q <= '0;
        end else if (!stall) begin
            if (flush) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

    // hazard unit relies on a frozen record while stalled
    a_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> $stable(q))
        else $error("EX/MEM record changed during stall");

endmodule

// File: src/exec_stage.sv
// stall and flush come from an external hazard unit; register-file writes from the wb port
module exec_stage (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 valid_in,
    input  ex_pkg::word_t        pc_in,
    input  ex_pkg::word_t        pc4_in,
    input  ex_pkg::reg_idx_t     rs1_idx,
    input  ex_pkg::reg_idx_t     rs2_idx,
    input  ex_pkg::reg_idx_t     rd_idx,
    input  ex_pkg::alu_op_e      alu_op,
    input  ex_pkg::alu_a_sel_e   alu_a_sel,
    input  ex_pkg::alu_b_sel_e   alu_b_sel,
    input  logic [11:0]          imm_i,
    input  logic [11:0]          imm_s,
    input  logic [12:0]          imm_sb,
    input  logic [20:0]          imm_uj,
    input  ex_pkg::word_t        imm_u,
    input  logic [4:0]           shamt,
    input  logic                 imm_shamt_sel,
    input  ex_pkg::branch_type_e branch_type,
    input  logic                 is_branch,
    input  logic                 is_jump,
    input  logic                 j_sel,
    input  logic                 reg_write_in,
    input  logic                 illegal_in,
    input  ex_pkg::vsetvl_type_e vsetvl_type,
    input  logic [10:0]          vtype_imm,
    input  logic [4:0]           zimm,
    input  logic                 fwd_rs1,
    input  logic                 fwd_rs2,
    input  ex_pkg::word_t        fwd_data,
    input  logic                 wb_en,
    input  ex_pkg::reg_idx_t     wb_rd,
    input  ex_pkg::word_t        wb_data,
    input  logic                 stall,
    input  logic                 flush,
    output logic                 out_valid,
    output logic                 out_reg_write,
    output ex_pkg::reg_idx_t     out_rd,
    output logic                 out_branch_taken,
    output logic                 out_illegal,
    output ex_pkg::word_t        out_result,
    output ex_pkg::word_t        out_brj_addr,
    output ex_pkg::vtype_t       out_vtype,
    output ex_pkg::word_t        out_pc
);
    import ex_pkg::*;

    word_t   rs1_data;
    word_t   rs2_data;
    word_t   alu_a;
    word_t   alu_b;
    alu_op_e alu_op_q;
    word_t   alu_result;
    logic    branch_taken;
    word_t   brj_addr;
    word_t   vl;
    vtype_t  vtype_cfg;
    ex_mem_t q;

    ex_operand_if ops ();

    reg_file u_reg_file (
        .CLK(CLK), .nRST(nRST),
        .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .wen(wb_en), .rd(wb_rd), .wdata(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    ex_operand_sel u_operand_sel (
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2), .fwd_data(fwd_data),
        .pc_in(pc_in), .pc4_in(pc4_in),
        .imm_i(imm_i), .imm_s(imm_s), .imm_sb(imm_sb), .imm_uj(imm_uj), .imm_u(imm_u),
        .shamt(shamt), .imm_shamt_sel(imm_shamt_sel),
        .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel), .alu_op_in(alu_op),
        .ops(ops.src),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op_q)
    );

    alu u_alu (.a(alu_a), .b(alu_b), .op(alu_op_q), .result(alu_result));

    branch_jump_unit u_branch_jump (
        .ops(ops.sink),
        .branch_type(branch_type), .is_branch(is_branch),
        .is_jump(is_jump), .j_sel(j_sel),
        .branch_taken(branch_taken), .brj_addr(brj_addr)
    );

    vcfg_unit u_vcfg (
        .ops(ops.sink),
        .vsetvl_type(vsetvl_type), .vtype_imm(vtype_imm), .zimm(zimm),
        .rs1_idx(rs1_idx), .vl(vl), .vtype_out(vtype_cfg)
    );

    ex_mem_reg u_ex_mem_reg (
        .CLK(CLK), .nRST(nRST), .stall(stall), .flush(flush),
        .valid_in(valid_in), .reg_write_in(reg_write_in), .rd_in(rd_idx),
        .illegal_in(illegal_in), .vsetvl_type(vsetvl_type),
        .ops(ops.sink),
        .alu_result(alu_result), .branch_taken(branch_taken), .brj_addr(brj_addr),
        .vl(vl), .vtype(vtype_cfg),
        .q(q)
    );

    // unpack the record onto flat ports
    assign out_valid        = q.valid;
    assign out_reg_write    = q.reg_write;
    assign out_rd           = q.rd;
    assign out_branch_taken = q.branch_taken;
    assign out_illegal      = q.illegal;
    assign out_result       = q.result;
    assign out_brj_addr     = q.brj_addr;
    assign out_vtype        = q.vtype;
    assign out_pc           = q.pc;

endmodule

// File: tb/tb_vectors.svh
// row table for tb_exec_stage; rows assume x3=5, x4=-3, x5=5, x6=32, x7=3 preloaded
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
    word_t        pc;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    alu_op_e      op;
    alu_a_sel_e   a_sel;
    alu_b_sel_e   b_sel;
    logic [11:0]  imm_i;
    logic [12:0]  imm_sb;
    logic [20:0]  imm_uj;
    branch_type_e br;
    logic         is_br;
    logic         is_j;
    logic         j_sel;
    logic         rw;
    logic         illegal;
    vsetvl_type_e cfg;
    logic [10:0]  vt_imm;
    logic [4:0]   zimm;
    logic         fwd1;
    logic         fwd2;
    word_t        fwd_data;
    logic         stall;
    logic         flush;
    // expected outputs one cycle later
    logic         e_valid;
    logic         e_rw;
    reg_idx_t     e_rd;
    logic         e_taken;
    logic         e_illegal;
    word_t        e_result;
    word_t        e_brj;
    word_t        e_vtype;
    word_t        e_pc;
} vec_t;

vec_t  vecs[$];
string vec_names[$];

function automatic void add_vec(string name, vec_t v);
    vecs.push_back(v);
    vec_names.push_back(name);
endfunction

// ALU operands fixed to zero, so non-ALU rows show a zero result
function automatic vec_t blank_vec(word_t pc);
    vec_t v;
    v         = '0;
    v.pc      = pc;
    v.rd      = 5'd10;
    v.a_sel   = A_ZERO;
    v.b_sel   = B_IMM_U;
    // legal vtype on every row, only the config gate keeps it off non-config rows
    v.vt_imm  = 11'h0D3;
    v.e_valid = 1'b1;
    v.e_rd    = 5'd10;
    v.e_brj   = pc + 32'd4;
    v.e_pc    = pc;
    return v;
endfunction

function automatic vec_t alu_vec(word_t pc, reg_idx_t rs1, reg_idx_t rs2, alu_op_e op,
                                 alu_a_sel_e a_sel, alu_b_sel_e b_sel, logic [11:0] imm_i,
                                 word_t exp);
    vec_t v;
    v          = blank_vec(pc);
    v.rs1      = rs1;
    v.rs2      = rs2;
    v.op       = op;
    v.a_sel    = a_sel;
    v.b_sel    = b_sel;
    v.imm_i    = imm_i;
    v.rw       = 1'b1;
    v.e_rw     = 1'b1;
    v.e_result = exp;
    return v;
endfunction

function automatic vec_t branch_vec(word_t pc, reg_idx_t rs1, reg_idx_t rs2,
                                    branch_type_e br, logic [12:0] sb, logic taken,
                                    word_t exp_brj);
    vec_t v;
    v         = blank_vec(pc);
    v.rs1     = rs1;
    v.rs2     = rs2;
    v.br      = br;
    v.imm_sb  = sb;
    v.is_br   = 1'b1;
    v.e_taken = taken;
    v.e_brj   = exp_brj;
    return v;
endfunction

function automatic vec_t jump_vec(word_t pc, reg_idx_t rs1, logic j_sel, logic [11:0] imm_i,
                                  logic [20:0] uj, word_t exp_brj);
    vec_t v;
    v        = blank_vec(pc);
    v.rs1    = rs1;
    v.is_j   = 1'b1;
    v.j_sel  = j_sel;
    v.imm_i  = imm_i;
    v.imm_uj = uj;
    v.e_brj  = exp_brj;
    return v;
endfunction

function automatic vec_t cfg_vec(word_t pc, reg_idx_t rs1, vsetvl_type_e cfg,
                                 logic [10:0] vt_imm, logic [4:0] zimm, word_t exp_vl,
                                 word_t exp_vtype);
    vec_t v;
    v          = blank_vec(pc);
    v.rs1      = rs1;
    v.cfg      = cfg;
    v.vt_imm   = vt_imm;
    v.zimm     = zimm;
    v.rw       = 1'b1;
    v.e_rw     = 1'b1;
    v.e_result = exp_vl;
    v.e_vtype  = exp_vtype;
    return v;
endfunction

task automatic build_table();
    vec_t v;
    // ALU on preloaded registers
    add_vec("add x3 x4", alu_vec('h100, 3, 4, ALU_ADD, A_RS1, B_RS2, 0, 'h2));
    add_vec("sub x3 x4", alu_vec('h104, 3, 4, ALU_SUB, A_RS1, B_RS2, 0, 'h8));
    add_vec("and x3 x4", alu_vec('h108, 3, 4, ALU_AND, A_RS1, B_RS2, 0, 'h5));
    add_vec("or x3 x4", alu_vec('h10C, 3, 4, ALU_OR, A_RS1, B_RS2, 0, 'hFFFFFFFD));
    add_vec("xor x3 x4", alu_vec('h110, 3, 4, ALU_XOR, A_RS1, B_RS2, 0, 'hFFFFFFF8));
    add_vec("slt x4 x3", alu_vec('h114, 4, 3, ALU_SLT, A_RS1, B_RS2, 0, 'h1));
    add_vec("sltu x4 x3", alu_vec('h118, 4, 3, ALU_SLTU, A_RS1, B_RS2, 0, 'h0));
    add_vec("addi x3 -1", alu_vec('h11C, 3, 0, ALU_ADD, A_RS1, B_IMM_OR_SHAMT, 'hFFF, 'h4));
    add_vec("pc plus imm", alu_vec('h120, 0, 0, ALU_ADD, A_PC, B_IMM_OR_SHAMT, 'h010, 'h130));
    add_vec("read x0", alu_vec('h124, 0, 0, ALU_ADD, A_RS1, B_RS2, 0, 'h0));
    // memory-stage forwarding
    v = alu_vec('h140, 3, 4, ALU_ADD, A_RS1, B_RS2, 0, 'hFFD);
    v.fwd1     = 1'b1;
    v.fwd_data = 'h1000;
    add_vec("fwd rs1", v);
    v = alu_vec('h144, 3, 4, ALU_SUB, A_RS1, B_RS2, 0, 'h3);
    v.fwd2     = 1'b1;
    v.fwd_data = 'h2;
    add_vec("fwd rs2", v);
    v = alu_vec('h148, 3, 4, ALU_ADD, A_RS1, B_RS2, 0, 'hE);
    v.fwd1     = 1'b1;
    v.fwd2     = 1'b1;
    v.fwd_data = 'h7;
    add_vec("fwd both", v);
    // each branch type taken and not taken
    add_vec("beq taken", branch_vec('h200, 3, 5, BEQ, 'h010, 1, 'h210));
    add_vec("beq not", branch_vec('h200, 3, 4, BEQ, 'h010, 0, 'h204));
    add_vec("bne taken", branch_vec('h300, 3, 4, BNE, 'h1FF0, 1, 'h2F0));
    add_vec("bne not", branch_vec('h300, 3, 5, BNE, 'h1FF0, 0, 'h304));
    add_vec("blt taken", branch_vec('h400, 4, 3, BLT, 'h020, 1, 'h420));
    add_vec("blt not", branch_vec('h400, 3, 4, BLT, 'h020, 0, 'h404));
    add_vec("bge taken", branch_vec('h500, 3, 4, BGE, 'h008, 1, 'h508));
    add_vec("bge not", branch_vec('h500, 4, 3, BGE, 'h008, 0, 'h504));
    add_vec("bltu taken", branch_vec('h600, 3, 4, BLTU, 'h100, 1, 'h700));
    add_vec("bltu not", branch_vec('h600, 4, 3, BLTU, 'h100, 0, 'h604));
    add_vec("bgeu taken", branch_vec('h700, 4, 3, BGEU, 'h00C, 1, 'h70C));
    add_vec("bgeu not", branch_vec('h700, 3, 4, BGEU, 'h00C, 0, 'h704));
    // jal backwards, jalr with odd sum
    add_vec("jal", jump_vec('h800, 0, 1, 'h000, 'h1FFF00, 'h700));
    add_vec("jalr bit0", jump_vec('h804, 4, 0, 'h00A, 'h0, 'h6));
    // VLEN 16 bytes
    add_vec("vsetvli x0 vlmax", cfg_vec('hB00, 0, VSETVLI, 'h011, 0, 8, 'h11));
    add_vec("vsetvli clamp", cfg_vec('hB04, 6, VSETVLI, 'h008, 0, 8, 'h08));
    add_vec("vsetvli avl 3", cfg_vec('hB08, 7, VSETVLI, 'h043, 0, 3, 'h43));
    add_vec("vsetvli lmul half", cfg_vec('hB0C, 6, VSETVLI, 'h007, 0, 8, 'h07));
    add_vec("vsetivli zimm 5", cfg_vec('hB10, 0, VSETIVLI, 'h080, 5, 5, 'h80));
    add_vec("vsetivli clamp", cfg_vec('hB14, 0, VSETIVLI, 'h010, 31, 4, 'h10));
    add_vec("reserved sew", cfg_vec('hB18, 7, VSETVLI, 'h018, 0, 0, 'h80000000));
    add_vec("reserved lmul", cfg_vec('hB1C, 7, VSETVLI, 'h004, 0, 0, 'h80000000));
    add_vec("vtype upper", cfg_vec('hB20, 7, VSETVLI, 'h100, 0, 0, 'h80000000));
    // stall keeps the previous row, flush zeroes the record
    add_vec("before stall", alu_vec('hA00, 3, 5, ALU_ADD, A_RS1, B_RS2, 0, 'hA));
    v = alu_vec('hA40, 4, 3, ALU_SUB, A_RS1, B_RS2, 0, 'hA);
    v.stall = 1'b1;
    v.rd    = 5'd12;
    v.e_brj = 'hA04;
    v.e_pc  = 'hA00;
    add_vec("stall holds", v);
    v = alu_vec('hA80, 3, 5, ALU_ADD, A_RS1, B_RS2, 0, 'h0);
    v.flush   = 1'b1;
    v.e_valid = 1'b0;
    v.e_rw    = 1'b0;
    v.e_rd    = '0;
    v.e_brj   = 'h0;
    v.e_pc    = 'h0;
    add_vec("flush clears", v);
    add_vec("after flush", alu_vec('hAC0, 3, 5, ALU_ADD, A_RS1, B_RS2, 0, 'hA));
    // illegal squashes the write and the redirect
    v = alu_vec('hC00, 3, 5, ALU_ADD, A_RS1, B_RS2, 0, 'hA);
    v.illegal   = 1'b1;
    v.e_illegal = 1'b1;
    v.e_rw      = 1'b0;
    add_vec("illegal alu", v);
    v = branch_vec('hC40, 3, 5, BEQ, 'h040, 0, 'hC80);
    v.illegal   = 1'b1;
    v.e_illegal = 1'b1;
    add_vec("illegal branch", v);
endtask

`endif

// File: tb/tb_exec_stage.sv
// one table row per clock; inputs change on the falling edge, outputs sampled 10 ns after rise
module tb_exec_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import ex_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_PRELOAD  = 8;
    localparam int NUM_RAND     = 10;

    logic         CLK = 1'b0;
    logic         nRST;
    logic         valid_in;
    word_t        pc_in;
    word_t        pc4_in;
    reg_idx_t     rs1_idx;
    reg_idx_t     rs2_idx;
    reg_idx_t     rd_idx;
    alu_op_e      alu_op;
    alu_a_sel_e   alu_a_sel;
    alu_b_sel_e   alu_b_sel;
    logic [11:0]  imm_i;
    logic [11:0]  imm_s;
    logic [12:0]  imm_sb;
    logic [20:0]  imm_uj;
    word_t        imm_u;
    logic [4:0]   shamt;
    logic         imm_shamt_sel;
    branch_type_e branch_type;
    logic         is_branch;
    logic         is_jump;
    logic         j_sel;
    logic         reg_write_in;
    logic         illegal_in;
    vsetvl_type_e vsetvl_type;
    logic [10:0]  vtype_imm;
    logic [4:0]   zimm;
    logic         fwd_rs1;
    logic         fwd_rs2;
    word_t        fwd_data;
    logic         wb_en;
    reg_idx_t     wb_rd;
    word_t        wb_data;
    logic         stall;
    logic         flush;
    logic         out_valid;
    logic         out_reg_write;
    reg_idx_t     out_rd;
    logic         out_branch_taken;
    logic         out_illegal;
    word_t        out_result;
    word_t        out_brj_addr;
    vtype_t       out_vtype;
    word_t        out_pc;

    integer seed = 34141;
    int     errors = 0;
    int     row_errs;
    int     tests = 0;
    int     failed_tests = 0;
    string  cur_name;
    word_t  r1;
    word_t  r2;

    `include "tb_vectors.svh"

    exec_stage UUT (.*);

    always #(PERIOD / 2) CLK = ~CLK;

    // reference results from the RV32I definitions
    function automatic word_t model_alu(alu_op_e op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic init_inputs();
        nRST          = 1'b0;
        valid_in      = 1'b0;
        pc_in         = '0;
        pc4_in        = '0;
        rs1_idx       = '0;
        rs2_idx       = '0;
        rd_idx        = '0;
        alu_op        = ALU_ADD;
        alu_a_sel     = A_ZERO;
        alu_b_sel     = B_IMM_U;
        imm_i         = '0;
        imm_s         = '0;
        imm_sb        = '0;
        imm_uj        = '0;
        imm_u         = '0;
        shamt         = '0;
        imm_shamt_sel = 1'b0;
        branch_type   = BEQ;
        is_branch     = 1'b0;
        is_jump       = 1'b0;
        j_sel         = 1'b0;
        reg_write_in  = 1'b0;
        illegal_in    = 1'b0;
        vsetvl_type   = NOT_CFG;
        vtype_imm     = '0;
        zimm          = '0;
        fwd_rs1       = 1'b0;
        fwd_rs2       = 1'b0;
        fwd_data      = '0;
        wb_en         = 1'b0;
        wb_rd         = '0;
        wb_data       = '0;
        stall         = 1'b0;
        flush         = 1'b0;
    endtask

    // write lands on the following rising edge
    task automatic write_reg(reg_idx_t idx, word_t data);
        @(negedge CLK);
        wb_en   = 1'b1;
        wb_rd   = idx;
        wb_data = data;
    endtask

    task automatic drive_vec(vec_t v);
        valid_in     = 1'b1;
        pc_in        = v.pc;
        pc4_in       = v.pc + 32'd4;
        rs1_idx      = v.rs1;
        rs2_idx      = v.rs2;
        rd_idx       = v.rd;
        alu_op       = v.op;
        alu_a_sel    = v.a_sel;
        alu_b_sel    = v.b_sel;
        imm_i        = v.imm_i;
        imm_sb       = v.imm_sb;
        imm_uj       = v.imm_uj;
        branch_type  = v.br;
        is_branch    = v.is_br;
        is_jump      = v.is_j;
        j_sel        = v.j_sel;
        reg_write_in = v.rw;
        illegal_in   = v.illegal;
        vsetvl_type  = v.cfg;
        vtype_imm    = v.vt_imm;
        zimm         = v.zimm;
        fwd_rs1      = v.fwd1;
        fwd_rs2      = v.fwd2;
        fwd_data     = v.fwd_data;
        stall        = v.stall;
        flush        = v.flush;
    endtask

    task automatic compare(string sig, word_t got, word_t exp);
        assert (got === exp)
        else begin
            $display("Fail %s: %s = %h, expected %h", cur_name, sig, got, exp);
            row_errs++;
            errors++;
        end
    endtask

    task automatic check_outputs(vec_t v);
        compare("out_valid", word_t'(out_valid), word_t'(v.e_valid));
        compare("out_reg_write", word_t'(out_reg_write), word_t'(v.e_rw));
        compare("out_rd", word_t'(out_rd), word_t'(v.e_rd));
        compare("out_branch_taken", word_t'(out_branch_taken), word_t'(v.e_taken));
        compare("out_illegal", word_t'(out_illegal), word_t'(v.e_illegal));
        compare("out_result", out_result, v.e_result);
        compare("out_brj_addr", out_brj_addr, v.e_brj);
        compare("out_vtype", word_t'(out_vtype), v.e_vtype);
        compare("out_pc", out_pc, v.e_pc);
    endtask

    task automatic report_row();
        tests++;
        if (row_errs == 0) begin
            $display("%-20s ok", cur_name);
        end else begin
            failed_tests++;
            $display("%-20s mismatch in %0d outputs", cur_name, row_errs);
        end
    endtask

    // present at the falling edge, check once the register has captured
    task automatic run_vec(string name, vec_t v);
        @(negedge CLK);
        drive_vec(v);
        @(posedge CLK);
        #(PERIOD / 4);
        cur_name = name;
        row_errs = 0;
        check_outputs(v);
        report_row();
    endtask

    initial begin
        vec_t    v;
        alu_op_e rand_ops [NUM_RAND];
        rand_ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                     ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU};
        init_inputs();
        build_table();
        repeat (RESET_CYCLES) @(negedge CLK);
        // record must read zero straight out of reset
        cur_name = "reset state";
        row_errs = 0;
        check_outputs(vec_t'('0));
        report_row();
        nRST = 1'b1;
        r1 = $random(seed);
        r2 = $random(seed);
        // x0 write must be dropped
        write_reg(0, 'hDEADBEEF);
        write_reg(1, r1);
        write_reg(2, r2);
        write_reg(3, 'h5);
        write_reg(4, 'hFFFFFFFD);
        write_reg(5, 'h5);
        write_reg(6, 'h20);
        write_reg(7, 'h3);
        @(negedge CLK);
        wb_en = 1'b0;
        foreach (vecs[i]) begin
            run_vec(vec_names[i], vecs[i]);
        end
        // random operands in x1 and x2
        for (int i = 0; i < NUM_RAND; i++) begin
            v = alu_vec('hD00 + 4 * i, 1, 2, rand_ops[i], A_RS1, B_RS2, 0,
                        model_alu(rand_ops[i], r1, r2));
            run_vec($sformatf("rand %s", rand_ops[i].name()), v);
        end
        $display("tests %0d, failed %0d, check errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // three cycles of slack per row plus reset
    initial begin
        int limit;
        #1;
        limit = (vecs.size() + NUM_RAND + NUM_PRELOAD) * 3 * PERIOD
                + (RESET_CYCLES + 2) * PERIOD;
        #(limit);
        $display("watchdog expired at %0t, the test sequence did not finish", $time);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+tb
src/ex_pkg.sv
src/ex_operand_if.sv
src/reg_file.sv
src/ex_operand_sel.sv
src/alu.sv
src/branch_jump_unit.sv
src/vcfg_unit.sv
src/ex_mem_reg.sv
src/exec_stage.sv
tb/tb_exec_stage.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - src/ex_pkg.sv
      - src/ex_operand_if.sv
      - src/reg_file.sv
      - src/ex_operand_sel.sv
      - src/alu.sv
      - src/branch_jump_unit.sv
      - src/vcfg_unit.sv
      - src/ex_mem_reg.sv
      - src/exec_stage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_exec_stage.sv
